//--- design/lsu_pkg.sv
package lsu_pkg;

  // major opcodes handled by the unit.
  localparam logic [6:0] op_load  = 7'b0000011;
  localparam logic [6:0] op_store = 7'b0100011;

  // funct3 codes for loads and stores.
  localparam logic [2:0] f3_b  = 3'b000;
  localparam logic [2:0] f3_h  = 3'b001;
  localparam logic [2:0] f3_w  = 3'b010;
  localparam logic [2:0] f3_bu = 3'b100;
  localparam logic [2:0] f3_hu = 3'b101;

  // data sram size in 32-bit words.
  localparam int mem_depth_words = 256;

  // lsu bus state encoding.
  localparam logic [2:0] st_idle    = 3'd0;
  localparam logic [2:0] st_rd_addr = 3'd1;
  localparam logic [2:0] st_rd_data = 3'd2;
  localparam logic [2:0] st_write   = 3'd3;
  localparam logic [2:0] st_wr_resp = 3'd4;

  typedef enum logic [1:0] {
    sz_byte = 2'd0,
    sz_half = 2'd1,
    sz_word = 2'd2
  } size_t;

  // loads use the i-type immediate, stores the split s-type one.
  typedef union packed {
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_view;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s_view;
  } instr_u;

endpackage

//--- design/lsu_ifs.sv
`timescale 1ns/1ps

interface ls_cmd_if import lsu_pkg::*; ();
  logic        valid;
  logic        is_load;
  logic        is_store;
  size_t       size;
  logic        is_signed;
  logic [31:0] imm;
  logic [4:0]  rd;

  modport src (output valid, is_load, is_store, size, is_signed, imm, rd);
  modport dst (input valid, is_load, is_store, size, is_signed, imm, rd);
endinterface

interface axi_lite_if;
  logic [31:0] araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic        rvalid;
  logic        rready;
  logic [31:0] awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic        bvalid;
  logic        bready;

  modport master (
    output araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
    input  arready, rdata, rvalid, awready, wready, bvalid
  );
  modport slave (
    input  araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
    output arready, rdata, rvalid, awready, wready, bvalid
  );
endinterface

//--- design/ls_decode.sv
`timescale 1ns/1ps

module ls_decode import lsu_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   instr_valid,
  input  instr_u instr,
  input  logic   done,
  ls_cmd_if.src  cmd
);

  logic       busy;
  logic [2:0] f3;

  assign f3 = instr.i_view.funct3;

  always_comb begin
    cmd.valid     = instr_valid;
    cmd.rd        = instr.i_view.rd;
    cmd.is_load   = 1'b0;
    cmd.is_store  = 1'b0;
    cmd.is_signed = !f3[2];
    cmd.imm       = {{20{instr.i_view.imm[11]}}, instr.i_view.imm};
    case (f3[1:0])
      2'b00:   cmd.size = sz_byte;
      2'b01:   cmd.size = sz_half;
      default: cmd.size = sz_word;
    endcase
    case (instr.i_view.opcode)
      op_load: begin
        cmd.is_load = (f3 == f3_b) || (f3 == f3_h) || (f3 == f3_w) ||
                      (f3 == f3_bu) || (f3 == f3_hu);
      end
      op_store: begin
        cmd.is_store = (f3 == f3_b) || (f3 == f3_h) || (f3 == f3_w);
        cmd.imm      = {{20{instr.s_view.imm_hi[6]}}, instr.s_view.imm_hi,
                        instr.s_view.imm_lo};
      end
      default: ;
    endcase
  end

  // one access in flight, a new one may start in the done cycle.
  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
    end else if (instr_valid) begin
      busy <= 1'b1;
    end else if (done) begin
      busy <= 1'b0;
    end
  end

  a_no_issue_while_busy: assert property (
    @(posedge clk) disable iff (rst) instr_valid |-> (!busy || done)
  );

endmodule

//--- design/ls_execute.sv
`timescale 1ns/1ps

module ls_execute import lsu_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  ls_cmd_if.dst       cmd,
  input  logic [31:0] rs1_val,
  input  logic [31:0] rs2_val,
  output logic        req_valid,
  output logic        req_load,
  output logic        req_store,
  output logic        req_signed,
  output logic        req_misaligned,
  output logic [31:0] req_addr,
  output logic [31:0] req_wdata,
  output logic [3:0]  req_wstrb,
  output size_t       req_size,
  output logic [4:0]  req_rd
);

  logic [31:0] ea;
  logic [3:0]  strb;
  logic        bad_align;

  assign ea = rs1_val + cmd.imm;

  always_comb begin
    case (cmd.size)
      sz_byte: strb = 4'b0001;
      sz_half: strb = 4'b0011;
      default: strb = 4'b1111;
    endcase
  end

  assign bad_align = ((cmd.size == sz_half) && ea[0]) ||
                     ((cmd.size == sz_word) && (ea[1:0] != 2'b00));

  always_ff @(posedge clk) begin
    if (rst) begin
      req_valid <= 1'b0;
    end else begin
      req_valid <= cmd.valid;
    end
  end

  // held until the next command, so the lsu and top can read it late.
  always_ff @(posedge clk) begin
    if (cmd.valid) begin
      req_load       <= cmd.is_load;
      req_store      <= cmd.is_store;
      req_signed     <= cmd.is_signed;
      req_size       <= cmd.size;
      req_rd         <= cmd.rd;
      req_addr       <= ea;
      req_wdata      <= rs2_val << {ea[1:0], 3'b000};
      req_wstrb      <= strb << ea[1:0];
      req_misaligned <= bad_align && (cmd.is_load || cmd.is_store);
    end
  end

endmodule

//--- design/lsu.sv
`timescale 1ns/1ps

module lsu import lsu_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        req_valid,
  input  logic        req_load,
  input  logic        req_store,
  input  logic        req_signed,
  input  logic        req_misaligned,
  input  logic [31:0] req_addr,
  input  logic [31:0] req_wdata,
  input  logic [3:0]  req_wstrb,
  input  size_t       req_size,
  axi_lite_if.master  bus,
  output logic        done,
  output logic        load_we,
  output logic        misaligned,
  output logic [31:0] rd_word,
  output logic [1:0]  rd_addr_lo,
  output size_t       rd_size,
  output logic        rd_signed
);

  logic [2:0] state;
  logic       aw_done;
  logic       w_done;
  logic       aw_ok;
  logic       w_ok;
  logic       done_r;
  logic       r_fire;
  logic       b_fire;
  logic       start;

  assign start  = (state == st_idle) && req_valid;
  assign r_fire = (state == st_rd_data) && bus.rvalid && bus.rready;
  assign b_fire = (state == st_wr_resp) && bus.bvalid && bus.bready;
  assign aw_ok  = aw_done || (bus.awvalid && bus.awready);
  assign w_ok   = w_done || (bus.wvalid && bus.wready);

  // stores finish on the b beat itself, everything else one cycle later.
  assign done = done_r || b_fire;

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= st_idle;
      bus.arvalid <= 1'b0;
      bus.awvalid <= 1'b0;
      bus.wvalid  <= 1'b0;
      bus.rready  <= 1'b0;
      bus.bready  <= 1'b0;
      aw_done     <= 1'b0;
      w_done      <= 1'b0;
      done_r      <= 1'b0;
      load_we     <= 1'b0;
      misaligned  <= 1'b0;
    end else begin
      bus.rready <= 1'b1;
      bus.bready <= 1'b1;
      done_r     <= 1'b0;
      load_we    <= 1'b0;
      misaligned <= 1'b0;
      case (state)
        st_idle: begin
          if (req_valid) begin
            if (req_misaligned || !(req_load || req_store)) begin
              done_r     <= 1'b1;
              misaligned <= req_misaligned;
            end else if (req_load) begin
              bus.arvalid <= 1'b1;
              state       <= st_rd_addr;
            end else begin
              bus.awvalid <= 1'b1;
              bus.wvalid  <= 1'b1;
              state       <= st_write;
            end
          end
        end
        st_rd_addr: begin
          if (bus.arready) begin
            bus.arvalid <= 1'b0;
            state       <= st_rd_data;
          end
        end
        st_rd_data: begin
          if (r_fire) begin
            done_r  <= 1'b1;
            load_we <= 1'b1;
            state   <= st_idle;
          end
        end
        st_write: begin
          if (bus.awvalid && bus.awready) bus.awvalid <= 1'b0;
          if (bus.wvalid && bus.wready) bus.wvalid <= 1'b0;
          if (aw_ok && w_ok) begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            state   <= st_wr_resp;
          end else begin
            aw_done <= aw_ok;
            w_done  <= w_ok;
          end
        end
        st_wr_resp: begin
          if (b_fire) state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      bus.araddr <= req_addr;
      bus.awaddr <= req_addr;
      bus.wdata  <= req_wdata;
      bus.wstrb  <= req_wstrb;
      rd_addr_lo <= req_addr[1:0];
      rd_size    <= req_size;
      rd_signed  <= req_signed;
    end
    if (r_fire) rd_word <= bus.rdata;
  end

  a_one_channel: assert property (
    @(posedge clk) disable iff (rst) !(bus.arvalid && bus.awvalid)
  );

  a_ar_hold: assert property (
    @(posedge clk) disable iff (rst) bus.arvalid && !bus.arready |=> bus.arvalid
  );

  a_aw_hold: assert property (
    @(posedge clk) disable iff (rst) bus.awvalid && !bus.awready |=> bus.awvalid
  );

  a_w_hold: assert property (
    @(posedge clk) disable iff (rst) bus.wvalid && !bus.wready |=> bus.wvalid
  );

endmodule

//--- design/axi_sram.sv
`timescale 1ns/1ps

module axi_sram import lsu_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  axi_lite_if.slave bus
);

  logic [31:0] mem [mem_depth_words];
  logic        ar_fire;
  logic        w_fire;

  assign ar_fire = bus.arvalid && bus.arready;
  assign w_fire  = bus.awvalid && bus.awready && bus.wvalid && bus.wready;

  // ready comes one cycle after valid, and only while no response is pending.
  always_ff @(posedge clk) begin
    if (rst) begin
      bus.arready <= 1'b0;
      bus.awready <= 1'b0;
      bus.wready  <= 1'b0;
      bus.rvalid  <= 1'b0;
      bus.bvalid  <= 1'b0;
    end else begin
      bus.arready <= bus.arvalid && !bus.arready && !bus.rvalid;
      bus.awready <= bus.awvalid && bus.wvalid && !bus.awready && !bus.bvalid;
      bus.wready  <= bus.awvalid && bus.wvalid && !bus.wready && !bus.bvalid;

      if (ar_fire) begin
        bus.rvalid <= 1'b1;
      end else if (bus.rvalid && bus.rready) begin
        bus.rvalid <= 1'b0;
      end

      if (w_fire) begin
        bus.bvalid <= 1'b1;
      end else if (bus.bvalid && bus.bready) begin
        bus.bvalid <= 1'b0;
      end
    end
  end

  // word index from bits 9:2, upper address bits wrap.
  always_ff @(posedge clk) begin
    if (ar_fire) bus.rdata <= mem[bus.araddr[9:2]];
    if (w_fire) begin
      for (int i = 0; i < 4; i++) begin
        if (bus.wstrb[i]) mem[bus.awaddr[9:2]][i*8 +: 8] <= bus.wdata[i*8 +: 8];
      end
    end
  end

  a_w_with_aw: assert property (
    @(posedge clk) disable iff (rst) bus.wvalid |-> bus.awvalid
  );

endmodule

//--- design/load_align.sv
`timescale 1ns/1ps

module load_align import lsu_pkg::*; (
  input  logic [31:0] rd_word,
  input  logic [1:0]  addr_lo,
  input  size_t       size,
  input  logic        is_signed,
  output logic [31:0] load_data
);

  logic [7:0]  byte_lane;
  logic [15:0] half_lane;

  always_comb begin
    case (addr_lo)
      2'd0:    byte_lane = rd_word[7:0];
      2'd1:    byte_lane = rd_word[15:8];
      2'd2:    byte_lane = rd_word[23:16];
      default: byte_lane = rd_word[31:24];
    endcase
  end

  // halfwords are aligned here, so only bit 1 picks the lane.
  assign half_lane = addr_lo[1] ? rd_word[31:16] : rd_word[15:0];

  always_comb begin
    case (size)
      sz_byte: begin
        load_data = {{24{is_signed && byte_lane[7]}}, byte_lane};
      end
      sz_half: begin
        load_data = {{16{is_signed && half_lane[15]}}, half_lane};
      end
      default: begin
        load_data = rd_word;
      end
    endcase
  end

endmodule

//--- design/lsu_top.sv
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        instr_valid,
  input  logic [31:0] instr,
  input  logic [31:0] rs1_val,
  input  logic [31:0] rs2_val,
  output logic        done,
  output logic        load_we,
  output logic [4:0]  load_rd,
  output logic [31:0] load_data,
  output logic        misaligned
);

  ls_cmd_if   cmd ();
  axi_lite_if bus ();

  logic        req_valid;
  logic        req_load;
  logic        req_store;
  logic        req_signed;
  logic        req_misaligned;
  logic [31:0] req_addr;
  logic [31:0] req_wdata;
  logic [3:0]  req_wstrb;
  size_t       req_size;
  logic [31:0] rd_word;
  logic [1:0]  rd_addr_lo;
  size_t       rd_size;
  logic        rd_signed;

  ls_decode u_decode (
    .clk, .rst, .instr_valid, .instr, .done, .cmd(cmd.src)
  );

  ls_execute u_execute (
    .clk, .rst, .cmd(cmd.dst), .rs1_val, .rs2_val,
    .req_valid, .req_load, .req_store, .req_signed, .req_misaligned,
    .req_addr, .req_wdata, .req_wstrb, .req_size, .req_rd(load_rd)
  );

  lsu u_lsu (
    .clk, .rst, .req_valid, .req_load, .req_store, .req_signed, .req_misaligned,
    .req_addr, .req_wdata, .req_wstrb, .req_size, .bus(bus.master),
    .done, .load_we, .misaligned, .rd_word, .rd_addr_lo, .rd_size, .rd_signed
  );

  axi_sram u_sram (.clk, .rst, .bus(bus.slave));

  load_align u_align (
    .rd_word, .addr_lo(rd_addr_lo), .size(rd_size), .is_signed(rd_signed), .load_data
  );

endmodule

//--- verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic rst
);

  localparam int reset_cycles = 4;

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // release lands just after an edge, like the other inputs.
  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst = 1'b0;
  end

endmodule

//--- verif/lsu_checker.sv
`timescale 1ns/1ps

module lsu_checker (
  input  logic        clk,
  input  logic        rst,
  input  logic        instr_valid,
  input  logic [31:0] instr,
  input  logic [31:0] rs1_val,
  input  logic [31:0] rs2_val,
  input  logic        done,
  input  logic        load_we,
  input  logic [4:0]  load_rd,
  input  logic [31:0] load_data,
  input  logic        misaligned,
  output int          n_errors
);

  localparam int done_limit = 20;

  // byte model of the sram, indexed by address bits 9:0.
  logic [7:0]  mem_bytes [1024];
  logic        pending;
  int          age;
  logic [6:0]  opc;
  logic [2:0]  f3;
  logic [31:0] imm;
  logic        p_load;
  logic        p_store;
  logic        p_mis;
  logic        p_signed;
  logic [31:0] p_addr;
  logic [31:0] p_data;
  logic [4:0]  p_rd;
  int          p_bytes;

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (got !== exp) begin
      $display("error: %s expected 0x%0h got 0x%0h", name, exp, got);
      n_errors++;
    end
  endtask

  // little endian gather, then extend from the top loaded byte.
  function automatic logic [31:0] expected_load();
    logic [31:0] val;
    logic [9:0]  ba;
    val = 32'd0;
    for (int b = 0; b < p_bytes; b++) begin
      ba = p_addr[9:0] + 10'(b);
      val[b*8 +: 8] = mem_bytes[ba];
    end
    if (p_signed && p_bytes == 1) val[31:8] = {24{val[7]}};
    if (p_signed && p_bytes == 2) val[31:16] = {16{val[15]}};
    return val;
  endfunction

  task automatic write_store();
    logic [9:0] ba;
    for (int b = 0; b < p_bytes; b++) begin
      ba = p_addr[9:0] + 10'(b);
      mem_bytes[ba] = p_data[b*8 +: 8];
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      pending = 1'b0;
      age = 0;
      n_errors = 0;
    end else begin
      if (done === 1'b1) begin
        if (!pending) begin
          $display("done pulsed with no instruction in flight");
          n_errors++;
        end else begin
          check_value("misaligned", 32'(p_mis), 32'(misaligned));
          check_value("load_we", 32'(p_load && !p_mis), 32'(load_we));
          if (p_load && !p_mis) begin
            check_value("load_rd", 32'(p_rd), 32'(load_rd));
            check_value("load_data", expected_load(), load_data);
          end
          if (p_store && !p_mis) write_store();
          pending = 1'b0;
        end
      end else begin
        check_value("done", 32'd0, 32'(done));
        check_value("load_we", 32'd0, 32'(load_we));
        check_value("misaligned", 32'd0, 32'(misaligned));
        if (pending) begin
          age++;
          if (age == done_limit) begin
            $display("no done within %0d cycles of the instruction", done_limit);
            n_errors++;
            pending = 1'b0;
          end
        end
      end

      if (instr_valid === 1'b1) begin
        opc = instr[6:0];
        f3 = instr[14:12];
        p_load = (opc == 7'b0000011) && (f3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});
        p_store = (opc == 7'b0100011) && (f3 inside {3'b000, 3'b001, 3'b010});
        if (opc == 7'b0100011) imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        else imm = {{20{instr[31]}}, instr[31:20]};
        p_addr = rs1_val + imm;
        p_data = rs2_val;
        p_rd = instr[11:7];
        p_signed = !f3[2];
        p_bytes = (f3[1:0] == 2'b00) ? 1 : (f3[1:0] == 2'b01) ? 2 : 4;
        p_mis = (p_load || p_store) && ((p_addr % p_bytes) != 0);
        pending = 1'b1;
        age = 0;
      end
    end
  end

endmodule

//--- verif/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb;

  localparam logic [6:0] opc_load  = 7'b0000011;
  localparam logic [6:0] opc_store = 7'b0100011;
  localparam logic [2:0] f3_b  = 3'b000;
  localparam logic [2:0] f3_h  = 3'b001;
  localparam logic [2:0] f3_w  = 3'b010;
  localparam logic [2:0] f3_bu = 3'b100;
  localparam logic [2:0] f3_hu = 3'b101;
  localparam int cycles_per_test = 20;
  localparam int random_pairs = 8;

  logic        clk;
  logic        rst;
  logic        instr_valid;
  logic [31:0] instr;
  logic [31:0] rs1_val;
  logic [31:0] rs2_val;
  logic        done;
  logic        load_we;
  logic [4:0]  load_rd;
  logic [31:0] load_data;
  logic        misaligned;
  int          n_errors;

  logic [31:0] tab_instr [$];
  logic [31:0] tab_rs1 [$];
  logic [31:0] tab_rs2 [$];
  string       tab_name [$];

  int seed;
  int cycles = 0;
  int limit = 1000;
  int n_ok = 0;
  int n_bad = 0;

  tb_clock clk_gen (.clk, .rst);

  lsu_top dut0 (
    .clk, .rst, .instr_valid, .instr, .rs1_val, .rs2_val,
    .done, .load_we, .load_rd, .load_data, .misaligned
  );

  lsu_checker chk (
    .clk, .rst, .instr_valid, .instr, .rs1_val, .rs2_val,
    .done, .load_we, .load_rd, .load_data, .misaligned, .n_errors
  );

  // register fields are don't care since operands come in on the ports.
  function automatic logic [31:0] encode_load(logic [2:0] f3, logic [4:0] rd, logic [11:0] imm);
    return {imm, 5'd1, f3, rd, opc_load};
  endfunction

  function automatic logic [31:0] encode_store(logic [2:0] f3, logic [11:0] imm);
    return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], opc_store};
  endfunction

  task automatic add_entry(input logic [31:0] i, input logic [31:0] a, input logic [31:0] d,
                           input string name);
    tab_instr.push_back(i);
    tab_rs1.push_back(a);
    tab_rs2.push_back(d);
    tab_name.push_back(name);
  endtask

  task automatic build_table();
    logic [31:0] addr;
    logic [31:0] data;
    add_entry(encode_store(f3_w, 12'h000), 32'h100, 32'hdeadbeef, "sw word 0x100");
    add_entry(encode_load(f3_w, 5'd5, 12'h000), 32'h100, 32'h0, "lw word 0x100");
    add_entry(encode_store(f3_b, 12'h001), 32'h100, 32'h0000005a, "sb lane 1");
    add_entry(encode_store(f3_b, 12'h003), 32'h100, 32'h112233a5, "sb lane 3");
    add_entry(encode_load(f3_w, 5'd6, 12'h000), 32'h100, 32'h0, "lw after sb");
    add_entry(encode_load(f3_b, 5'd7, 12'h003), 32'h100, 32'h0, "lb lane 3");
    add_entry(encode_load(f3_bu, 5'd8, 12'h003), 32'h100, 32'h0, "lbu lane 3");
    add_entry(encode_load(f3_b, 5'd9, 12'h001), 32'h100, 32'h0, "lb lane 1");
    add_entry(encode_store(f3_h, 12'h002), 32'h100, 32'h12348001, "sh upper half");
    add_entry(encode_load(f3_h, 5'd10, 12'h002), 32'h100, 32'h0, "lh upper half");
    add_entry(encode_load(f3_hu, 5'd11, 12'h002), 32'h100, 32'h0, "lhu upper half");
    add_entry(encode_load(f3_h, 5'd12, 12'h000), 32'h100, 32'h0, "lh lower half");
    add_entry(encode_store(f3_h, 12'h000), 32'h100, 32'h5555c3d2, "sh lower half");
    add_entry(encode_load(f3_h, 5'd22, 12'h000), 32'h100, 32'h0, "lh lower half negative");
    add_entry(encode_load(f3_hu, 5'd23, 12'h000), 32'h100, 32'h0, "lhu lower half");
    add_entry(encode_store(f3_w, 12'h000), 32'h104, 32'h01020304, "sw word 0x104");
    add_entry(encode_store(f3_b, 12'hffc), 32'h108, 32'h000000ff, "sb negative imm");
    add_entry(encode_store(f3_b, 12'h000), 32'h106, 32'h00000077, "sb lane 2");
    add_entry(encode_load(f3_w, 5'd13, 12'h000), 32'h104, 32'h0, "lw after sb 0x104");
    add_entry(encode_load(f3_b, 5'd14, 12'h000), 32'h104, 32'h0, "lb lane 0");
    add_entry(encode_load(f3_hu, 5'd15, 12'h002), 32'h104, 32'h0, "lhu lane 2");
    add_entry(encode_load(f3_h, 5'd16, 12'h001), 32'h100, 32'h0, "lh odd address");
    add_entry(encode_load(f3_w, 5'd17, 12'h002), 32'h100, 32'h0, "lw half aligned");
    add_entry(encode_store(f3_h, 12'h003), 32'h100, 32'hffffffff, "sh odd address");
    add_entry(encode_store(f3_w, 12'h001), 32'h104, 32'h0, "sw odd address");
    add_entry(encode_load(f3_w, 5'd18, 12'h000), 32'h100, 32'h0, "lw 0x100 unchanged");
    add_entry(encode_load(f3_w, 5'd19, 12'h000), 32'h104, 32'h0, "lw 0x104 unchanged");
    add_entry(32'h00500093, 32'h100, 32'h0, "addi is other");
    add_entry(encode_load(3'b011, 5'd20, 12'h000), 32'h101, 32'h0, "ld is other");
    add_entry(encode_store(3'b100, 12'h001), 32'h100, 32'h0, "bad store funct3");
    // the sram ignores the upper address bits, so they are random too.
    for (int k = 0; k < random_pairs; k++) begin
      addr = $random(seed) & 32'hfffffffc;
      data = $random(seed);
      add_entry(encode_store(f3_w, 12'h000), addr, data, "random sw");
      add_entry(encode_load(f3_w, 5'(k + 1), 12'h000), addr, 32'h0, "random lw");
      add_entry(encode_load(f3_b, 5'd21, 12'(k % 4)), addr, 32'h0, "random lb");
    end
  endtask

  task automatic wait_for_done();
    do @(posedge clk); while (done !== 1'b1);
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > limit) begin
      $display("timeout after %0d cycles, the DUT stopped answering", cycles);
      $display("Something failed");
      $finish;
    end
  end

  initial begin
    int errors_before;
    instr_valid = 1'b0;
    instr = 32'h0;
    rs1_val = 32'h0;
    rs2_val = 32'h0;
    seed = 85068;
    build_table();
    limit = cycles_per_test * tab_instr.size() + 4 + 8;
    @(negedge rst);
    repeat (2) @(posedge clk);
    #1;
    for (int k = 0; k < tab_instr.size(); k++) begin
      errors_before = n_errors;
      instr = tab_instr[k];
      rs1_val = tab_rs1[k];
      rs2_val = tab_rs2[k];
      instr_valid = 1'b1;
      @(posedge clk);
      #1;
      instr_valid = 1'b0;
      wait_for_done();
      #1;
      if (n_errors == errors_before) begin
        n_ok++;
        $display("test %0d %s: ok", k, tab_name[k]);
      end else begin
        n_bad++;
        $display("test %0d %s: FAILED", k, tab_name[k]);
      end
    end
    repeat (2) @(posedge clk);
    $display("%0d tests passed, %0d failed, %0d errors", n_ok, n_bad, n_errors);
    if (n_bad == 0 && n_errors == 0 && n_ok == tab_instr.size()) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- lsu_sub.f
design/lsu_pkg.sv
design/lsu_ifs.sv
design/ls_decode.sv
design/ls_execute.sv
design/lsu.sv
design/axi_sram.sv
design/load_align.sv
design/lsu_top.sv
verif/tb_clock.sv
verif/lsu_checker.sv
verif/lsu_tb.sv

//--- Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 --top-module lsu_tb -f lsu_sub.f -o lsu_sim

run: compile
	@out="$$(./obj_dir/lsu_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir
